// ==== src.f ====
source/rv_isa_pkg.sv
source/core_cfg_pkg.sv
source/inst_fetch.sv
source/inst_queue.sv
source/int_regfile.sv
source/int_exec.sv
source/rv32i_lite_core.sv
tb/core_tb.sv

// ==== tb/core_tests.txt ====
// addr     word     chk wr rd value    status
// chk 1 means the line's instruction has an expected retire record
00000000_00500093_1_1_01_00000005_00 // addi x1, x0, 5
00000004_FFD08113_1_1_02_00000002_00 // addi x2, x1, -3
00000008_00312193_1_1_03_00000001_00 // slti x3, x2, 3
0000000C_FFF13213_1_1_04_00000001_00 // sltiu x4, x2, -1
00000010_FFF12293_1_1_05_00000000_00 // slti x5, x2, -1
00000014_FFF0C313_1_1_06_FFFFFFFA_00 // xori x6, x1, -1
00000018_0A00E393_1_1_07_000000A5_00 // ori x7, x1, 0xa0
0000001C_7F037413_1_1_08_000007F0_00 // andi x8, x6, 0x7f0
00000020_800014B7_1_1_09_80001000_00 // lui x9, 0x80001
00000024_00439513_1_1_0A_00000A50_00 // slli x10, x7, 4
00000028_0084D593_1_1_0B_00800010_00 // srli x11, x9, 8
0000002C_4084D613_1_1_0C_FF800010_00 // srai x12, x9, 8
00000030_00A606B3_1_1_0D_FF800A60_00 // add x13, x12, x10
00000034_40D08733_1_1_0E_007FF5A5_00 // sub x14, x1, x13
00000038_004097B3_1_1_0F_0000000A_00 // sll x15, x1, x4
0000003C_00162833_1_1_10_00000001_00 // slt x16, x12, x1
00000040_001638B3_1_1_11_00000000_00 // sltu x17, x12, x1
00000044_0083C933_1_1_12_00000755_00 // xor x18, x7, x8
00000048_006659B3_1_1_13_0000003F_00 // srl x19, x12, x6
0000004C_40665A33_1_1_14_FFFFFFFF_00 // sra x20, x12, x6
00000050_00A9EAB3_1_1_15_00000A7F_00 // or x21, x19, x10
00000054_014AFB33_1_1_16_00000A7F_00 // and x22, x21, x20
00000058_00708013_1_0_00_00000000_00 // addi x0, x1, 7
0000005C_00100BB3_1_1_17_00000005_00 // add x23, x0, x1
00000060_00000073_1_0_00_00000000_01 // ecall
00000064_001B8C13_1_1_18_00000006_00 // addi x24, x23, 1
00000068_00100073_1_0_00_00000000_02 // ebreak
0000006C_100C0C93_1_1_19_00000106_00 // addi x25, x24, 0x100
00000070_02208D33_1_0_1A_00000000_08 // mul x26, x1, x2 is unsupported
00000074_00609D33_1_1_1A_14000000_00 // sll x26, x1, x6
00000078_019D0DB3_1_1_1B_14000106_00 // add x27, x26, x25
0000007C_FFFFFEB7_1_1_1D_FFFFF000_00 // lui x29, 0xfffff
00000080_FFFE8E93_1_1_1D_FFFFEFFF_00 // addi x29, x29, -1
00000084_00000013_0_0_00_00000000_00 // nop filler
00000088_00000013_0_0_00_00000000_00 // nop filler
0000008C_00000013_0_0_00_00000000_00 // nop filler
00000090_00000013_0_0_00_00000000_00 // nop filler
00000094_00000013_0_0_00_00000000_00 // nop filler
00000098_00000013_0_0_00_00000000_00 // nop filler
0000009C_00000013_0_0_00_00000000_00 // nop filler
000000A0_00000013_0_0_00_00000000_00 // nop filler

// ==== tb/core_tb.sv ====
//////////////////////////////
// Testbench for the reduced RV32I core with
// a stalling instruction memory and retire checks
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_tb
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;
();

    localparam int    CLK_HALF     = 4;
    localparam int    RST_CYCLES   = 16;
    localparam int    OSTD         = 4;
    localparam addr_t BOOT_ADDR    = '0;
    localparam int    MAX_LINES    = 64;
    localparam int    RETIRE_LIMIT = 200;

    // Data file line holds addr[119:88] word[87:56] chk[55:52] wr[51:48]
    // rd[47:40] value[39:8] status[7:0]
    localparam int    LINE_W       = 120;

    logic                aclk;
    logic                rst;
    logic                imem_arvalid;
    addr_t               imem_araddr;
    logic                imem_arready;
    logic                imem_rvalid;
    xlen_t               imem_rdata;
    logic                imem_rready;
    logic                retire_valid;
    logic                retire_rd_wr;
    reg_idx_t            retire_rd_addr;
    xlen_t               retire_rd_val;
    logic [STATUS_W-1:0] status;

    logic [LINE_W-1:0]   test_mem [MAX_LINES];
    int                  n_lines;
    logic [31:0]         lfsr_state;
    addr_t               pending [$];
    addr_t               next_addr;
    logic                mem_on;

    rv32i_lite_core #(
        .BOOT_ADDR (BOOT_ADDR),
        .OSTD_NUM  (OSTD),
        .RV32E     (0)
    ) dut (
        .aclk           (aclk),
        .rst            (rst),
        .imem_arvalid   (imem_arvalid),
        .imem_araddr    (imem_araddr),
        .imem_arready   (imem_arready),
        .imem_rvalid    (imem_rvalid),
        .imem_rdata     (imem_rdata),
        .imem_rready    (imem_rready),
        .retire_valid   (retire_valid),
        .retire_rd_wr   (retire_rd_wr),
        .retire_rd_addr (retire_rd_addr),
        .retire_rd_val  (retire_rd_val),
        .status         (status)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #CLK_HALF aclk = ~aclk;
        end
    end

    //////////////////////////////
    // Helpers and checks
    //////////////////////////////

    // Galois LFSR stepped once per random bit
    function automatic logic rand_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input logic [STATUS_W-1:0] got,
                                input logic [STATUS_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
        end
    endtask

    // Lines end at the first unwritten or zero program word
    task automatic load_tests();
        logic done;
        $readmemh("tb/core_tests.txt", test_mem);
        n_lines = 0;
        done    = 1'b0;
        while (!done && (n_lines < MAX_LINES)) begin
            if ($isunknown(test_mem[n_lines]) || (test_mem[n_lines][87:56] == '0)) begin
                done = 1'b1;
            end else begin
                if (test_mem[n_lines][119:88] != BOOT_ADDR + addr_t'(4 * n_lines)) begin
                    abort_run("data file addresses are not sequential words");
                end
                n_lines++;
            end
        end
        if (n_lines == 0) begin
            abort_run("no program words found in the data file");
        end
    endtask

    task automatic wait_retire();
        int waited;
        waited = 0;
        @(negedge aclk);
        while (!retire_valid) begin
            waited++;
            if (waited > RETIRE_LIMIT) begin
                abort_run("no retire within limit");
            end
            @(negedge aclk);
        end
    endtask

    //////////////////////////////
    // Instruction memory
    //////////////////////////////

    // Returns in request order and a new address slot, each randomly held off
    task automatic respond_cycle();
        addr_t      addr;
        int         idx;
        inst_word_u word;
        logic       hold;
        check_flag("imem_rready", imem_rready, 1'b1);
        imem_rvalid = 1'b0;
        if (pending.size() > 0) begin
            hold = rand_bit();
            if (!hold) begin
                addr = pending.pop_front();
                if ((addr[1:0] != 2'b00) || (addr < BOOT_ADDR) ||
                    ((addr - BOOT_ADDR) >= addr_t'(4 * n_lines))) begin
                    abort_run("fetch address lies outside the program");
                end
                idx         = int'((addr - BOOT_ADDR) >> 2);
                word        = test_mem[idx][87:56];
                imem_rdata  = word;
                imem_rvalid = 1'b1;
            end
        end
        imem_arready = !rand_bit();
        if (imem_arvalid && imem_arready) begin
            // Straight-line code fetches consecutive words
            check_addr("imem_araddr", imem_araddr, next_addr);
            next_addr = next_addr + addr_t'(4);
            pending.push_back(imem_araddr);
            if (pending.size() > OSTD) begin
                abort_run("more fetch requests outstanding than queue entries");
            end
        end
    endtask

    always @(negedge aclk) begin
        if (mem_on) begin
            respond_cycle();
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        int line;
        rst          = 1'b1;
        imem_arready = 1'b0;
        imem_rvalid  = 1'b0;
        imem_rdata   = '0;
        mem_on       = 1'b0;
        next_addr    = BOOT_ADDR;
        lfsr_state   = 32'h7401;
        load_tests();

        repeat (RST_CYCLES) @(posedge aclk);
        @(negedge aclk);
        check_flag("imem_arvalid", imem_arvalid, 1'b0);
        check_flag("imem_rready", imem_rready, 1'b1);
        check_flag("retire_valid", retire_valid, 1'b0);
        check_status("status", status, '0);
        rst    <= 1'b0;
        mem_on <= 1'b1;

        // First request right after reset release
        @(negedge aclk);
        check_flag("imem_arvalid", imem_arvalid, 1'b1);
        check_addr("imem_araddr", imem_araddr, BOOT_ADDR);

        // Filler lines carry no expected record
        for (line = 0; line < n_lines; line++) begin
            if (test_mem[line][55:52] != 4'h0) begin
                wait_retire();
                check_flag("retire_rd_wr", retire_rd_wr, test_mem[line][48]);
                check_reg_idx("retire_rd_addr", retire_rd_addr,
                              reg_idx_t'(test_mem[line][44:40]));
                if (test_mem[line][48]) begin
                    check_value("retire_rd_val", retire_rd_val,
                                xlen_t'(test_mem[line][39:8]));
                end
                check_status("status", status, test_mem[line][7:0]);
            end
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/rv32i_lite_core.sv ====
//////////////////////////////
// Reduced RV32I core top level
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module rv32i_lite_core
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;
#(
    parameter addr_t BOOT_ADDR = '0,
    parameter int    OSTD_NUM  = 8,
    parameter int    RV32E     = 0
)(
    input  logic                aclk,
    input  logic                rst,
    // Instruction fetch channels
    output logic                imem_arvalid,
    output addr_t               imem_araddr,
    input  logic                imem_arready,
    input  logic                imem_rvalid,
    input  xlen_t               imem_rdata,
    output logic                imem_rready,
    // Retire trace
    output logic                retire_valid,
    output logic                retire_rd_wr,
    output reg_idx_t            retire_rd_addr,
    output xlen_t               retire_rd_val,
    output logic [STATUS_W-1:0] status
);

    logic       q_push;
    logic       q_pop;
    logic       q_not_empty;
    inst_word_u q_head;
    reg_idx_t   rs1_addr;
    reg_idx_t   rs2_addr;
    xlen_t      rs1_val;
    xlen_t      rs2_val;
    logic       rd_wr;
    reg_idx_t   rd_addr;
    xlen_t      rd_val;

    // Each return already owns a queue entry through the fetch credits
    assign imem_rready = 1'b1;
    assign q_push      = imem_rvalid & imem_rready;

    //////////////////////////////
    // Fetch and queue
    //////////////////////////////

    inst_fetch #(
        .BOOT_ADDR (BOOT_ADDR),
        .OSTD_NUM  (OSTD_NUM)
    ) fetch (
        .aclk    (aclk),
        .rst     (rst),
        .arvalid (imem_arvalid),
        .araddr  (imem_araddr),
        .arready (imem_arready),
        .pop     (q_pop)
    );

    inst_queue #(
        .OSTD_NUM (OSTD_NUM)
    ) queue (
        .aclk      (aclk),
        .rst       (rst),
        .push      (q_push),
        .push_word (imem_rdata),
        .pop       (q_pop),
        .not_empty (q_not_empty),
        .head_word (q_head)
    );

    //////////////////////////////
    // Execute and registers
    //////////////////////////////

    int_exec #(
        .RV32E (RV32E)
    ) exec (
        .aclk           (aclk),
        .rst            (rst),
        .not_empty      (q_not_empty),
        .head_word      (q_head),
        .pop            (q_pop),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .rd_wr          (rd_wr),
        .rd_addr        (rd_addr),
        .rd_val         (rd_val),
        .retire_valid   (retire_valid),
        .retire_rd_wr   (retire_rd_wr),
        .retire_rd_addr (retire_rd_addr),
        .retire_rd_val  (retire_rd_val),
        .status         (status)
    );

    int_regfile #(
        .RV32E (RV32E)
    ) regs (
        .aclk     (aclk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .rd_wr    (rd_wr),
        .rd_addr  (rd_addr),
        .rd_val   (rd_val)
    );

endmodule

`default_nettype wire

// ==== source/int_exec.sv ====
//////////////////////////////
// Decoder, integer ALU, trap detection
// and retire register
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module int_exec
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;
#(
    parameter int RV32E = 0
)(
    input  logic                aclk,
    input  logic                rst,
    // Instruction queue head
    input  logic                not_empty,
    input  inst_word_u          head_word,
    output logic                pop,
    // Register file
    output reg_idx_t            rs1_addr,
    output reg_idx_t            rs2_addr,
    input  xlen_t               rs1_val,
    input  xlen_t               rs2_val,
    output logic                rd_wr,
    output reg_idx_t            rd_addr,
    output xlen_t               rd_val,
    // Trace and status
    output logic                retire_valid,
    output logic                retire_rd_wr,
    output reg_idx_t            retire_rd_addr,
    output xlen_t               retire_rd_val,
    output logic [STATUS_W-1:0] status
);

    logic       legal;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       uses_rd;
    logic       is_ecall;
    logic       is_ebreak;
    logic       sub_op;
    logic       sra_op;
    logic       bad_reg;
    logic       illegal;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      op_b;
    logic [4:0] shamt;
    xlen_t      alu_res;

    // One instruction per cycle whenever a word is waiting
    assign pop = not_empty;

    assign funct3   = head_word.r.funct3;
    assign funct7   = head_word.r.funct7;
    assign rs1_addr = head_word.r.rs1;
    assign rs2_addr = head_word.r.rs2;
    assign rd_addr  = head_word.r.rd;
    assign imm_i    = {{(XLEN-12){head_word.i.imm[11]}}, head_word.i.imm};

    //////////////////////////////
    // Decode
    //////////////////////////////

    always_comb begin
        legal     = 1'b0;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        uses_rd   = 1'b0;
        is_ecall  = 1'b0;
        is_ebreak = 1'b0;
        sub_op    = 1'b0;
        sra_op    = 1'b0;
        op_b      = rs2_val;
        case (head_word.r.opcode)
            OP: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                uses_rd  = 1'b1;
                sub_op   = (funct7 == F7_ALT);
                sra_op   = (funct7 == F7_ALT);
                // Alternate funct7 only exists for SUB and SRA
                legal = (funct7 == F7_BASE) ||
                        ((funct7 == F7_ALT) &&
                         ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
            end
            OP_IMM: begin
                uses_rs1 = 1'b1;
                uses_rd  = 1'b1;
                op_b     = imm_i;
                sra_op   = (funct7 == F7_ALT);
                // Upper immediate bits of shifts act as funct7
                case (funct3)
                    F3_SLL:     legal = (funct7 == F7_BASE);
                    F3_SRL_SRA: legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    default:    legal = 1'b1;
                endcase
            end
            LUI: begin
                uses_rd = 1'b1;
                legal   = 1'b1;
            end
            SYSTEM: begin
                if ((funct3 == F3_PRIV) && (head_word.i.rs1 == '0) &&
                    (head_word.i.rd == '0)) begin
                    is_ecall  = (head_word.i.imm == IMM_ECALL);
                    is_ebreak = (head_word.i.imm == IMM_EBREAK);
                end
                legal = is_ecall || is_ebreak;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Upper 16 registers do not exist under RV32E
    assign bad_reg = (RV32E != 0) &&
                     ((uses_rs1 && rs1_addr[4]) ||
                      (uses_rs2 && rs2_addr[4]) ||
                      (uses_rd  && rd_addr[4]));

    assign illegal = !legal || bad_reg;

    //////////////////////////////
    // ALU
    //////////////////////////////

    assign shamt = op_b[4:0];

    always_comb begin
        alu_res = '0;
        case (funct3)
            F3_ADD_SUB: begin
                if (sub_op) begin
                    alu_res = rs1_val - op_b;
                end else begin
                    alu_res = rs1_val + op_b;
                end
            end
            F3_SLL:  alu_res = rs1_val << shamt;
            F3_SLT:  alu_res = {{(XLEN-1){1'b0}}, ($signed(rs1_val) < $signed(op_b))};
            F3_SLTU: alu_res = {{(XLEN-1){1'b0}}, (rs1_val < op_b)};
            F3_XOR:  alu_res = rs1_val ^ op_b;
            F3_SRL_SRA: begin
                if (sra_op) begin
                    alu_res = $signed(rs1_val) >>> shamt;
                end else begin
                    alu_res = rs1_val >> shamt;
                end
            end
            F3_OR:   alu_res = rs1_val | op_b;
            F3_AND:  alu_res = rs1_val & op_b;
        endcase
    end

    // LUI fills the upper 20 bits, low bits zero
    assign rd_val = (head_word.u.opcode == LUI) ? {head_word.u.imm, 12'b0} : alu_res;

    // Write lands at the end of the pop cycle
    assign rd_wr = pop && uses_rd && !illegal && (rd_addr != '0);

    //////////////////////////////
    // Retire register
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            retire_valid <= 1'b0;
            retire_rd_wr <= 1'b0;
            status       <= '0;
        end else begin
            retire_valid <= pop;
            retire_rd_wr <= rd_wr;
            status                 <= '0;
            status[STATUS_ECALL]   <= pop && is_ecall;
            status[STATUS_EBREAK]  <= pop && is_ebreak;
            status[STATUS_ILLEGAL] <= pop && illegal;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            retire_rd_addr <= rd_addr;
            retire_rd_val  <= rd_val;
        end
    end

endmodule

`default_nettype wire

// ==== source/int_regfile.sv ====
//////////////////////////////
// Integer register file, 2 read / 1 write
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module int_regfile
    import core_cfg_pkg::*;
#(
    // 1 limits the file to 16 registers
    parameter int RV32E = 0
)(
    input  logic     aclk,
    input  logic     rst,
    input  reg_idx_t rs1_addr,
    input  reg_idx_t rs2_addr,
    output xlen_t    rs1_val,
    output xlen_t    rs2_val,
    input  logic     rd_wr,
    input  reg_idx_t rd_addr,
    input  xlen_t    rd_val
);

    localparam int NREGS = (RV32E != 0) ? 16 : 32;
    localparam int IDX_W = $clog2(NREGS);

    xlen_t regs [NREGS];

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && (rd_addr != '0)) begin
            regs[rd_addr[IDX_W-1:0]] <= rd_val;
        end
    end

    // x0 is hardwired to zero
    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr[IDX_W-1:0]];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr[IDX_W-1:0]];

endmodule

`default_nettype wire

// ==== source/inst_queue.sv ====
//////////////////////////////
// In-order FIFO of fetched instruction words
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module inst_queue
    import rv_isa_pkg::*;
#(
    // Number of entries, power of two
    parameter int OSTD_NUM = 8
)(
    input  logic       aclk,
    input  logic       rst,
    input  logic       push,
    input  inst_word_u push_word,
    input  logic       pop,
    output logic       not_empty,
    output inst_word_u head_word
);

    localparam int PTR_W = $clog2(OSTD_NUM);

    inst_word_u       mem [OSTD_NUM];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // Storage, written at the tail
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // Pointers wrap naturally on a power of two depth
    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    assign not_empty = (count != '0);
    // Oldest word shown without a register stage
    assign head_word = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== source/inst_fetch.sv ====
//////////////////////////////
// Instruction fetch address generator
// with outstanding request credits
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module inst_fetch
    import core_cfg_pkg::*;
#(
    // First address fetched after reset
    parameter addr_t BOOT_ADDR = '0,
    // Requests in flight plus words queued, power of two
    parameter int    OSTD_NUM  = 8
)(
    input  logic  aclk,
    input  logic  rst,
    // Read address channel
    output logic  arvalid,
    output addr_t araddr,
    input  logic  arready,
    // Credit return from the queue
    input  logic  pop
);

    //////////////////////////////
    // Credit counter
    //////////////////////////////

    localparam int CNT_W = $clog2(OSTD_NUM) + 1;
    localparam logic [CNT_W-1:0] CREDIT_MAX = CNT_W'(OSTD_NUM);

    logic [CNT_W-1:0] credit;
    logic [CNT_W-1:0] credit_next;
    logic             ar_fire;

    assign ar_fire = arvalid & arready;

    // One credit taken per accepted address, one given back per pop
    always_comb begin
        credit_next = credit;
        if (ar_fire && !pop) begin
            credit_next = credit + 1'b1;
        end else if (!ar_fire && pop) begin
            credit_next = credit - 1'b1;
        end
    end

    //////////////////////////////
    // Address channel
    //////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            credit  <= '0;
            arvalid <= 1'b0;
            araddr  <= BOOT_ADDR;
        end else begin
            credit <= credit_next;

            // Next word address once the current one is taken
            if (ar_fire) begin
                araddr <= araddr + addr_t'(4);
            end

            // A raised request is held until the memory accepts it
            if (!arvalid || arready) begin
                arvalid <= (credit_next < CREDIT_MAX);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/core_cfg_pkg.sv ====
//////////////////////////////
// Core widths, register index type
// and status word bit positions
//////////////////////////////

`default_nettype none

package core_cfg_pkg;

    localparam int XLEN   = 32;
    localparam int ADDR_W = 32;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [4:0]        reg_idx_t;

    //////////////////////////////
    // Status word
    //////////////////////////////

    localparam int STATUS_W = 8;

    // Bit 2 and bits 7:4 are reserved and read as zero
    localparam int STATUS_ECALL   = 0;
    localparam int STATUS_EBREAK  = 1;
    localparam int STATUS_ILLEGAL = 3;

endpackage

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
//////////////////////////////
// RV32I opcodes, function codes and
// the decoded views of an instruction word
//////////////////////////////

`default_nettype none

package rv_isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 codes of the integer ALU
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_PRIV    = 3'b000;

    // funct7 of plain ops, and of SUB / SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // SYSTEM immediates
    localparam logic [11:0] IMM_ECALL  = 12'h000;
    localparam logic [11:0] IMM_EBREAK = 12'h001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_view_t;

    // One 32-bit word, three encodings
    typedef union packed {
        r_view_t r;
        i_view_t i;
        u_view_t u;
    } inst_word_u;

endpackage

`default_nettype wire
